/* sim.f */
hdl/ptw_pkg.sv
hdl/ptw_port_arbiter.sv
hdl/ptw_onehot_select.sv
hdl/ptw_level_counter.sv
hdl/ptw_pte_eval.sv
hdl/ptw_walk_fsm.sv
hdl/ptw_top.sv
tests/ptw_assertions.sv
tests/ptw_checker.sv
tests/ptw_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ptw_tb -f sim.f -o ptw_sim
	./obj_dir/ptw_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/ptw_tb.sv */
`default_nettype none

module ptw_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 300;
  localparam int RUN_LIMIT = 200000;  // cycles for the whole run

  logic                   i_clk;
  logic                   i_reset_n;
  logic [2:0]             i_ptw_req_valid;
  logic [2:0][19:0]       i_ptw_req_vpn;
  logic [2:0][21:0]       i_ptw_satp_ppn;
  logic [2:0]             o_ptw_req_ready;
  logic [2:0]             o_ptw_resp_valid;
  logic [31:0]            o_ptw_resp_pte;
  logic [0:0]             o_ptw_resp_level;
  logic                   o_l1d_req_valid;
  logic [33:0]            o_l1d_paddr;
  logic                   i_l1d_resp_valid;
  ptw_pkg::l1d_status_t   i_l1d_status;
  logic [31:0]            i_l1d_data;
  logic                   o_l2_req_valid;
  logic [33:0]            o_l2_req_paddr;
  logic                   i_l2_req_ready;
  logic                   i_l2_resp_valid;
  logic [31:0]            i_l2_resp_data;

  logic [31:0] mem [4096];
  logic [15:0] lfsr;
  logic [2:0]  acc_mask;
  logic        l1d_pend;
  logic [33:0] l1d_addr;
  logic        l2_busy;
  logic        l2_counting;
  int          l2_cnt;
  logic [33:0] l2_addr;
  int          tests;
  int          errors;
  int          cycles;

  ptw_top u_ptw_top (.*);

  ptw_checker u_checker (
    .i_clk, .i_reset_n, .i_req_valid(i_ptw_req_valid), .i_req_ready(o_ptw_req_ready),
    .i_req_vpn(i_ptw_req_vpn), .i_satp_ppn(i_ptw_satp_ppn), .i_resp_valid(o_ptw_resp_valid),
    .i_resp_pte(o_ptw_resp_pte), .i_resp_level(o_ptw_resp_level),
    .i_l1d_req_valid(o_l1d_req_valid), .i_l1d_paddr(o_l1d_paddr), .i_l1d_resp_valid,
    .i_l1d_status(i_l1d_status), .i_l2_req_valid(o_l2_req_valid), .i_l2_paddr(o_l2_req_paddr),
    .i_l2_resp_valid, .i_mem(mem), .o_tests(tests), .o_errors(errors)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    acc_mask = i_ptw_req_valid & o_ptw_req_ready;
  end

  always @(negedge i_clk) begin
    logic [31:0] r;
    if (i_reset_n) begin
      for (int p = 0; p < 3; p++) begin
        if (acc_mask[p]) i_ptw_req_valid[p] = 1'b0;
        draw(2, r);
        if (!i_ptw_req_valid[p] && r[1:0] == 2'b00) begin
          draw(20, r);
          i_ptw_req_vpn[p] = r[19:0];
          draw(2, r);
          i_ptw_satp_ppn[p] = 22'(r[1:0]);
          i_ptw_req_valid[p] = 1'b1;
        end
      end
      // l1d answers the request seen one cycle ago
      i_l1d_resp_valid = l1d_pend;
      if (l1d_pend) begin
        draw(2, r);
        i_l1d_status = r[1] ? (r[0] ? ptw_pkg::L1D_CONFLICT : ptw_pkg::L1D_MISS)
                            : ptw_pkg::L1D_HIT;
        i_l1d_data = (i_l1d_status == ptw_pkg::L1D_HIT) ? mem[l1d_addr[13:2]]
                                                         : ~mem[l1d_addr[13:2]];
      end
      l1d_pend = o_l1d_req_valid;
      l1d_addr = o_l1d_paddr;
      i_l2_resp_valid = 1'b0;
      if (i_l2_req_ready) begin  // taken at the last rising edge
        i_l2_req_ready = 1'b0;
        l2_busy = 1'b1;
        draw(3, r);
        l2_cnt = int'(r[2:0]);
      end
      if (l2_busy) begin
        if (l2_cnt == 0) begin
          i_l2_resp_valid = 1'b1;
          i_l2_resp_data = mem[l2_addr[13:2]];
          l2_busy = 1'b0;
        end else begin
          l2_cnt--;
        end
      end else if (o_l2_req_valid) begin
        if (!l2_counting) begin
          draw(5, r);
          l2_cnt = int'(r[2:0]) + ((r[4:3] == 2'b11) ? 40 : 0);  // long stall now and then
          l2_counting = 1'b1;
        end
        if (l2_cnt == 0) begin
          i_l2_req_ready = 1'b1;
          l2_addr = o_l2_req_paddr;
          l2_counting = 1'b0;
        end else begin
          l2_cnt--;
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] flags;
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_ptw_req_valid = '0;
    i_ptw_req_vpn = '0;
    i_ptw_satp_ppn = '0;
    i_l1d_resp_valid = 1'b0;
    i_l1d_status = ptw_pkg::L1D_HIT;
    i_l1d_data = '0;
    i_l2_req_ready = 1'b0;
    i_l2_resp_valid = 1'b0;
    i_l2_resp_data = '0;
    acc_mask = '0;
    l1d_pend = 1'b0;
    l1d_addr = '0;
    l2_busy = 1'b0;
    l2_counting = 1'b0;
    l2_cnt = 0;
    l2_addr = '0;
    lfsr = 16'd37;
    for (int i = 0; i < 4096; i++) begin
      draw(2, r);
      if (r[1:0] == 2'b00) begin
        flags = 32'h1;  // pointer to next level
      end else begin
        draw(4, flags);
      end
      draw(2, r);
      // ppn stays in pages 0..3 and bits 9:4 carry the address
      mem[i] = {20'd0, r[1:0], 6'(i[5:0] ^ i[11:6]), flags[3:0]};
    end
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    cycles = 0;
    while (tests < NUM_TESTS && cycles < RUN_LIMIT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (tests < NUM_TESTS) begin
      $display("timeout: only %0d of %0d walks completed", tests, NUM_TESTS);
    end
    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0 && tests >= NUM_TESTS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/ptw_checker.sv */
`default_nettype none

module ptw_checker (
  input  wire logic             i_clk,
  input  wire logic             i_reset_n,
  input  wire logic [2:0]       i_req_valid,
  input  wire logic [2:0]       i_req_ready,
  input  wire logic [2:0][19:0] i_req_vpn,
  input  wire logic [2:0][21:0] i_satp_ppn,
  input  wire logic [2:0]       i_resp_valid,
  input  wire logic [31:0]      i_resp_pte,
  input  wire logic [0:0]       i_resp_level,
  input  wire logic             i_l1d_req_valid,
  input  wire logic [33:0]      i_l1d_paddr,
  input  wire logic             i_l1d_resp_valid,
  input  wire logic [1:0]       i_l1d_status,
  input  wire logic             i_l2_req_valid,
  input  wire logic [33:0]      i_l2_paddr,
  input  wire logic             i_l2_resp_valid,
  input  wire logic [31:0]      i_mem [4096],
  output int                    o_tests,
  output int                    o_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WALK_LIMIT = 3000;

  logic [2:0]  prev_grant;
  logic        busy;
  logic [2:0]  exp_port;
  logic [33:0] exp_addr [2];
  logic [31:0] exp_pte;
  logic [0:0]  exp_level;
  int          idx;
  int          walk_cycles;
  logic        test_bad;

  // lowest valid port above the previous grant, wrapping around
  function automatic logic [2:0] rr_pick(input logic [2:0] valid, input logic [2:0] prev);
    int p;
    int k;
    p = -1;
    for (int i = 0; i < 3; i++) begin
      if (prev[i]) p = i;
    end
    for (int j = 0; j < 3; j++) begin
      k = (p + 1 + j) % 3;
      if (valid[k]) return 3'(1 << k);
    end
    return 3'b000;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      o_errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic model_walk(input logic [19:0] vpn, input logic [21:0] root);
    logic [33:0] a;
    logic [31:0] pte;
    logic        leaf;
    logic        bad;
    a = {root, 12'd0} + {vpn[19:10], 2'b00};
    exp_addr[0] = a;
    pte = i_mem[a[13:2]];
    leaf = pte[0] & (pte[1] | pte[2] | pte[3]);
    if (leaf && pte[19:10] != 10'd0) pte[0] = 1'b0;  // misaligned superpage
    bad = !pte[0] || (pte[2] && !pte[1]);
    if (leaf || bad) begin
      exp_pte = pte;
      exp_level = 1'b1;
    end else begin
      a = {pte[31:10], 12'd0} + {vpn[9:0], 2'b00};
      exp_addr[1] = a;
      exp_pte = i_mem[a[13:2]];
      exp_level = 1'b0;
    end
  endtask

  always @(posedge i_clk) begin
    logic [2:0] g;
    int p;
    if (!i_reset_n) begin
      prev_grant = '0;
      busy = 1'b0;
      o_tests = 0;
      o_errors = 0;
      test_bad = 1'b0;
    end else begin
      if (|i_req_ready) begin
        g = rr_pick(i_req_valid, prev_grant);
        compare_value("o_ptw_req_ready", 64'(i_req_ready), 64'(g));
        prev_grant = g;
        p = (g[0]) ? 0 : (g[1] ? 1 : 2);
        if (busy) begin
          $display("ERR t=%0t request accepted while a walk is running", $time);
          o_errors++;
        end
        model_walk(i_req_vpn[p], i_satp_ppn[p]);
        exp_port = g;
        busy = 1'b1;
        idx = 0;
        walk_cycles = 0;
        test_bad = 1'b0;
      end
      if (busy && (i_l1d_req_valid || i_l2_req_valid)) begin
        if (idx > 1 || (idx == 1 && exp_level == 1'b1)) begin
          $display("ERR t=%0t memory request after the final level", $time);
          o_errors++;
          test_bad = 1'b1;
        end else if (i_l1d_req_valid) begin
          compare_value("o_l1d_paddr", 64'(i_l1d_paddr), 64'(exp_addr[idx]));
        end else begin
          compare_value("o_l2_req_paddr", 64'(i_l2_paddr), 64'(exp_addr[idx]));
        end
      end
      if (busy && ((i_l1d_resp_valid && i_l1d_status == 2'(ptw_pkg::L1D_HIT)) ||
                   i_l2_resp_valid)) begin
        idx++;
      end
      if (|i_resp_valid) begin
        if (!busy) begin
          $display("ERR t=%0t response without an accepted request", $time);
          o_errors++;
        end else begin
          compare_value("o_ptw_resp_valid", 64'(i_resp_valid), 64'(exp_port));
          compare_value("o_ptw_resp_pte", 64'(i_resp_pte), 64'(exp_pte));
          compare_value("o_ptw_resp_level", 64'(i_resp_level), 64'(exp_level));
          $display("test %0d port %b level %0d pte %h %s", o_tests, exp_port, exp_level,
                   exp_pte, test_bad ? "mismatch" : "ok");
          o_tests++;
          busy = 1'b0;
        end
      end else if (busy) begin
        walk_cycles++;
        if (walk_cycles > WALK_LIMIT) begin
          $display("walk for port %b did not finish within %0d cycles", exp_port, WALK_LIMIT);
          o_errors++;
          o_tests++;
          busy = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tests/ptw_assertions.sv */
`default_nettype none

module ptw_assertions (
  input wire logic        i_clk,
  input wire logic        i_reset_n,
  input wire logic [2:0]  o_ptw_req_ready,
  input wire logic [2:0]  o_ptw_resp_valid,
  input wire logic        o_l1d_req_valid,
  input wire logic        i_l1d_resp_valid,
  input wire logic        o_l2_req_valid,
  input wire logic [33:0] o_l2_req_paddr,
  input wire logic        i_l2_req_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  a_ready_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_ptw_req_ready)) else $error("ready not one-hot");

  a_resp_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_ptw_resp_valid)) else $error("response valid not one-hot");

  // request held with the same address until taken
  a_l2_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_l2_req_valid && !i_l2_req_ready |=> o_l2_req_valid && $stable(o_l2_req_paddr))
    else $error("l2 request dropped or changed before ready");

  a_l1d_reply: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_l1d_req_valid |=> i_l1d_resp_valid) else $error("l1d reply missing");

endmodule

bind ptw_top ptw_assertions u_assertions (.*);

`default_nettype wire

/* hdl/ptw_top.sv */
`default_nettype none

module ptw_top (
  input  wire logic                                                 i_clk,
  input  wire logic                                                 i_reset_n,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0]                     i_ptw_req_valid,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0][ptw_pkg::VPN_W-1:0] i_ptw_req_vpn,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0][ptw_pkg::PPN_W-1:0] i_ptw_satp_ppn,
  output logic      [ptw_pkg::PTW_PORT_NUM-1:0]                     o_ptw_req_ready,
  output logic      [ptw_pkg::PTW_PORT_NUM-1:0]                     o_ptw_resp_valid,
  output logic      [ptw_pkg::PTE_W-1:0]                            o_ptw_resp_pte,
  output logic      [ptw_pkg::LEVEL_W-1:0]                          o_ptw_resp_level,
  output logic                                                      o_l1d_req_valid,
  output logic      [ptw_pkg::PADDR_W-1:0]                          o_l1d_paddr,
  input  wire logic                                                 i_l1d_resp_valid,
  input  wire ptw_pkg::l1d_status_t                                 i_l1d_status,
  input  wire logic [ptw_pkg::PTE_W-1:0]                            i_l1d_data,
  output logic                                                      o_l2_req_valid,
  output logic      [ptw_pkg::PADDR_W-1:0]                          o_l2_req_paddr,
  input  wire logic                                                 i_l2_req_ready,
  input  wire logic                                                 i_l2_resp_valid,
  input  wire logic [ptw_pkg::PTE_W-1:0]                            i_l2_resp_data
);

  logic [ptw_pkg::PTW_PORT_NUM-1:0] w_grant;
  logic [ptw_pkg::PTW_PORT_NUM-1:0] r_accept_oh;  // port owning the walk
  logic [ptw_pkg::VPN_W-1:0]        w_sel_vpn;
  logic [ptw_pkg::PPN_W-1:0]        w_sel_root_ppn;
  logic [ptw_pkg::VPN_FIELD_W-1:0]  w_vpn_field;
  logic [ptw_pkg::VPN_FIELD_W-1:0]  w_next_vpn_field;
  logic [ptw_pkg::LEVEL_W-1:0]      w_level;
  logic [ptw_pkg::PADDR_W-1:0]      w_paddr;
  logic w_accept, w_step, w_from_l2, w_resp_fire;
  logic w_last, w_leaf, w_bad;

  ptw_port_arbiter u_arbiter (
    .i_clk, .i_reset_n, .i_valid(i_ptw_req_valid), .i_update(w_accept), .o_grant(w_grant)
  );

  ptw_onehot_select #(.T(logic [ptw_pkg::VPN_W-1:0]), .WORDS(ptw_pkg::PTW_PORT_NUM)) u_sel_vpn (
    .i_onehot(w_grant), .i_data(i_ptw_req_vpn), .o_selected(w_sel_vpn)
  );
  ptw_onehot_select #(.T(logic [ptw_pkg::PPN_W-1:0]), .WORDS(ptw_pkg::PTW_PORT_NUM)) u_sel_root (
    .i_onehot(w_grant), .i_data(i_ptw_satp_ppn), .o_selected(w_sel_root_ppn)
  );

  ptw_level_counter u_level (
    .i_clk, .i_reset_n, .i_load(w_accept), .i_vpn(w_sel_vpn), .i_step(w_step),
    .o_level(w_level), .o_vpn_field(w_vpn_field), .o_next_vpn_field(w_next_vpn_field),
    .o_last(w_last)
  );

  ptw_pte_eval u_pte_eval (
    .i_clk, .i_reset_n, .i_load_root(w_accept), .i_root_ppn(w_sel_root_ppn),
    .i_root_field(w_vpn_field), .i_step(w_step), .i_next_field(w_next_vpn_field),
    .i_from_l2(w_from_l2), .i_l1d_data, .i_l2_data(i_l2_resp_data), .i_level(w_level),
    .o_paddr(w_paddr), .o_pte(o_ptw_resp_pte), .o_leaf(w_leaf), .o_bad(w_bad)
  );

  ptw_walk_fsm u_fsm (
    .i_clk, .i_reset_n, .i_any_valid(|i_ptw_req_valid), .i_l1d_resp_valid, .i_l1d_status,
    .i_l2_req_ready, .i_l2_resp_valid, .i_leaf(w_leaf), .i_bad(w_bad), .i_last(w_last),
    .o_accept(w_accept), .o_step(w_step), .o_from_l2(w_from_l2),
    .o_l1d_req_valid, .o_l2_req_valid, .o_resp_fire(w_resp_fire)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_accept_oh <= '0;
    end else if (w_accept) begin
      r_accept_oh <= w_grant;
    end
  end

  assign o_ptw_req_ready  = {ptw_pkg::PTW_PORT_NUM{w_accept}} & w_grant;
  assign o_ptw_resp_valid = {ptw_pkg::PTW_PORT_NUM{w_resp_fire}} & r_accept_oh;
  assign o_ptw_resp_level = w_level;  // level where the walk stopped
  assign o_l1d_paddr      = w_paddr;
  assign o_l2_req_paddr   = w_paddr;

endmodule

`default_nettype wire

/* hdl/ptw_walk_fsm.sv */
`default_nettype none

module ptw_walk_fsm (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire logic                 i_any_valid,
  input  wire logic                 i_l1d_resp_valid,
  input  wire ptw_pkg::l1d_status_t i_l1d_status,
  input  wire logic                 i_l2_req_ready,
  input  wire logic                 i_l2_resp_valid,
  input  wire logic                 i_leaf,
  input  wire logic                 i_bad,
  input  wire logic                 i_last,
  output logic                      o_accept,
  output logic                      o_step,
  output logic                      o_from_l2,
  output logic                      o_l1d_req_valid,
  output logic                      o_l2_req_valid,
  output logic                      o_resp_fire
);

  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    CHECK_L1D    = 3'd1,
    RESP_L1D     = 3'd2,
    L2_REQUEST   = 3'd3,
    L2_RESP_WAIT = 3'd4
  } state_t;

  state_t r_state;
  logic   w_fetched;
  logic   w_fin;

  // entry available this cycle, from either source
  assign w_fetched = ((r_state == RESP_L1D) & i_l1d_resp_valid &
                      (i_l1d_status == ptw_pkg::L1D_HIT)) |
                     ((r_state == L2_RESP_WAIT) & i_l2_resp_valid);
  assign w_fin     = i_leaf | i_bad | i_last;

  assign o_accept        = (r_state == IDLE) & i_any_valid;
  assign o_resp_fire     = w_fetched & w_fin;
  assign o_step          = w_fetched & ~w_fin;
  assign o_from_l2       = (r_state == L2_RESP_WAIT);
  assign o_l1d_req_valid = (r_state == CHECK_L1D);
  assign o_l2_req_valid  = (r_state == L2_REQUEST);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      case (r_state)
        IDLE: begin
          if (i_any_valid) begin
            r_state <= CHECK_L1D;
          end
        end
        CHECK_L1D: r_state <= RESP_L1D;
        RESP_L1D: begin
          case (i_l1d_status)
            ptw_pkg::L1D_HIT:  r_state <= (w_fin && i_l1d_resp_valid) ? IDLE : CHECK_L1D;
            ptw_pkg::L1D_MISS: r_state <= i_l1d_resp_valid ? L2_REQUEST : CHECK_L1D;
            default:           r_state <= CHECK_L1D;  // conflict, retry
          endcase
        end
        L2_REQUEST: begin
          if (i_l2_req_ready) begin
            r_state <= L2_RESP_WAIT;
          end
        end
        L2_RESP_WAIT: begin
          if (i_l2_resp_valid) begin
            r_state <= w_fin ? IDLE : CHECK_L1D;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset_n && (r_state == RESP_L1D) && !i_l1d_resp_valid) begin
      $error("ptw: l1d status missing one cycle after request");
    end
  end

endmodule

`default_nettype wire

/* hdl/ptw_pte_eval.sv */
`default_nettype none

module ptw_pte_eval (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset_n,
  input  wire logic                              i_load_root,
  input  wire logic [ptw_pkg::PPN_W-1:0]         i_root_ppn,
  input  wire logic [ptw_pkg::VPN_FIELD_W-1:0]   i_root_field,
  input  wire logic                              i_step,
  input  wire logic [ptw_pkg::VPN_FIELD_W-1:0]   i_next_field,
  input  wire logic                              i_from_l2,
  input  wire logic [ptw_pkg::PTE_W-1:0]         i_l1d_data,
  input  wire logic [ptw_pkg::PTE_W-1:0]         i_l2_data,
  input  wire logic [ptw_pkg::LEVEL_W-1:0]       i_level,
  output logic      [ptw_pkg::PADDR_W-1:0]       o_paddr,
  output logic      [ptw_pkg::PTE_W-1:0]         o_pte,
  output logic                                   o_leaf,
  output logic                                   o_bad
);

  logic [ptw_pkg::PADDR_W-1:0] r_paddr;
  logic [ptw_pkg::PTE_W-1:0]   w_raw;
  logic [ptw_pkg::PPN_W-1:0]   w_ppn;
  logic                        w_raw_leaf;
  logic                        w_misalign;

  function automatic logic [ptw_pkg::PADDR_W-1:0] pte_addr(
    input logic [ptw_pkg::PPN_W-1:0]       ppn,
    input logic [ptw_pkg::VPN_FIELD_W-1:0] field
  );
    return {ppn, {ptw_pkg::PG_IDX_W{1'b0}}} + ptw_pkg::PADDR_W'({field, 2'b00});
  endfunction

  assign w_raw = i_from_l2 ? i_l2_data : i_l1d_data;
  assign w_ppn = w_raw[ptw_pkg::PTE_PPN_LSB +: ptw_pkg::PPN_W];

  assign w_raw_leaf = w_raw[ptw_pkg::PTE_V] &
                      (w_raw[ptw_pkg::PTE_R] | w_raw[ptw_pkg::PTE_W_BIT] | w_raw[ptw_pkg::PTE_X]);
  // superpage must be 4MB aligned
  assign w_misalign = w_raw_leaf && (i_level != '0) &&
                      (w_ppn[ptw_pkg::VPN_FIELD_W-1:0] != '0);

  always_comb begin
    o_pte = w_raw;
    if (w_misalign) begin
      o_pte[ptw_pkg::PTE_V] = 1'b0;
    end
  end

  assign o_leaf = o_pte[ptw_pkg::PTE_V] &
                  (o_pte[ptw_pkg::PTE_R] | o_pte[ptw_pkg::PTE_W_BIT] | o_pte[ptw_pkg::PTE_X]);
  assign o_bad  = ~o_pte[ptw_pkg::PTE_V] |
                  (o_pte[ptw_pkg::PTE_W_BIT] & ~o_pte[ptw_pkg::PTE_R]);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_paddr <= '0;
    end else if (i_load_root) begin
      r_paddr <= pte_addr(i_root_ppn, i_root_field);
    end else if (i_step) begin
      r_paddr <= pte_addr(w_ppn, i_next_field);  // next level table
    end
  end

  assign o_paddr = r_paddr;

endmodule

`default_nettype wire

/* hdl/ptw_level_counter.sv */
`default_nettype none

module ptw_level_counter (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset_n,
  input  wire logic                              i_load,
  input  wire logic [ptw_pkg::VPN_W-1:0]         i_vpn,
  input  wire logic                              i_step,
  output logic      [ptw_pkg::LEVEL_W-1:0]       o_level,
  output logic      [ptw_pkg::VPN_FIELD_W-1:0]   o_vpn_field,
  output logic      [ptw_pkg::VPN_FIELD_W-1:0]   o_next_vpn_field,
  output logic                                   o_last
);

  logic [ptw_pkg::LEVEL_W-1:0] r_level;
  logic [ptw_pkg::VPN_W-1:0]   r_vpn;
  logic [ptw_pkg::LEVEL_W-1:0] w_next_level;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_level <= '0;
      r_vpn   <= '0;
    end else if (i_load) begin
      r_level <= ptw_pkg::LEVEL_W'(ptw_pkg::PG_LEVELS - 1);
      r_vpn   <= i_vpn;
    end else if (i_step) begin
      r_level <= w_next_level;
    end
  end

  assign w_next_level = r_level - ptw_pkg::LEVEL_W'(1);

  // on load the root field comes straight from the incoming vpn
  assign o_vpn_field = i_load ?
      i_vpn[(ptw_pkg::PG_LEVELS-1)*ptw_pkg::VPN_FIELD_W +: ptw_pkg::VPN_FIELD_W] :
      r_vpn[r_level*ptw_pkg::VPN_FIELD_W +: ptw_pkg::VPN_FIELD_W];
  assign o_next_vpn_field = r_vpn[w_next_level*ptw_pkg::VPN_FIELD_W +: ptw_pkg::VPN_FIELD_W];
  assign o_level = r_level;
  assign o_last  = (r_level == '0);

endmodule

`default_nettype wire

/* hdl/ptw_onehot_select.sv */
`default_nettype none

module ptw_onehot_select #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  wire logic [WORDS-1:0] i_onehot,
  input  wire T     [WORDS-1:0] i_data,
  output T                      o_selected
);

  always_comb begin
    o_selected = '0;
    for (int i = 0; i < WORDS; i++) begin
      if (i_onehot[i]) begin
        o_selected = o_selected | i_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ptw_port_arbiter.sv */
`default_nettype none

module ptw_port_arbiter (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset_n,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0] i_valid,
  input  wire logic                              i_update,
  output logic      [ptw_pkg::PTW_PORT_NUM-1:0] o_grant
);

  logic [ptw_pkg::PTW_PORT_NUM-1:0] r_ptr;     // last grant, one-hot
  logic [ptw_pkg::PTW_PORT_NUM-1:0] w_upper;
  logic [ptw_pkg::PTW_PORT_NUM-1:0] w_masked;
  logic [ptw_pkg::PTW_PORT_NUM-1:0] w_pick;

  // ports strictly above the last grant, none when pointer is zero
  assign w_upper  = ~(r_ptr | (r_ptr - 1'b1));
  assign w_masked = i_valid & w_upper;
  assign w_pick   = (|w_masked) ? w_masked : i_valid;  // wrap around
  assign o_grant  = w_pick & (~w_pick + 1'b1);  // lowest set bit

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else if (i_update) begin
      r_ptr <= o_grant;
    end
  end

endmodule

`default_nettype wire

/* hdl/ptw_pkg.sv */
`default_nettype none

package ptw_pkg;

  localparam int PTW_PORT_NUM = 3;  // itlb + two dtlb

  // Sv32 geometry
  localparam int VPN_W       = 20;
  localparam int VPN_FIELD_W = 10;
  localparam int PG_LEVELS   = 2;
  localparam int LEVEL_W     = 1;
  localparam int PPN_W       = 22;
  localparam int PADDR_W     = 34;
  localparam int PG_IDX_W    = 12;

  // entry layout
  localparam int PTE_W       = 32;
  localparam int PTE_V       = 0;
  localparam int PTE_R       = 1;
  localparam int PTE_W_BIT   = 2;
  localparam int PTE_X       = 3;
  localparam int PTE_PPN_LSB = 10;

  typedef enum logic [1:0] {
    L1D_HIT      = 2'd0,
    L1D_MISS     = 2'd1,
    L1D_CONFLICT = 2'd2  // port busy, try again
  } l1d_status_t;

endpackage

`default_nettype wire
